// ==== rv_exec_unit.f ====
+incdir+.
rv_exec_pkg.sv
rv_alu.sv
rv_divider.sv
rv_exec_ctrl.sv
rv_exec_unit.sv
tb_rv_exec_asserts.sv
tb_rv_exec_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it, log goes to sim.log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_rv_exec_unit \
    -f rv_exec_unit.f -o vsim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion errors so the testbench can report them
./obj_dir/vsim +verilator+error+limit+100000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== tb_rv_exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_cfg.svh"

module tb_rv_exec_unit;

    import rv_exec_pkg::*;

    localparam int NUM_OPS    = 300;
    localparam int MAX_CYCLES = NUM_OPS * (`RV_DIV_STEPS + 8) + 1000;
    localparam int ALU_LAT    = 1;                    // counted from the edge that samples req
    localparam int DIV_LAT    = `RV_DIV_STEPS + 4;

    logic                clk;
    logic                reset;
    logic                req;
    alu_op_t             op;
    logic                word;
    logic [`RV_XLEN-1:0] src1;
    logic [`RV_XLEN-1:0] src2;
    logic                ack;
    logic [`RV_XLEN-1:0] result;
    logic                taken;

    logic [31:0] seed;
    int          errors = 0;
    int          ops_done = 0;
    int          cycle_cnt = 0;

    rv_exec_unit uut (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .op     (op),
        .word   (word),
        .src1   (src1),
        .src2   (src2),
        .ack    (ack),
        .result (result),
        .taken  (taken)
    );

    bind rv_exec_unit tb_rv_exec_asserts u_asserts (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .ack    (ack),
        .result (result),
        .taken  (taken)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout, run still busy after %0d cycles", cycle_cnt);
            $display("Result: FAILED");
            $finish;
        end
    end

    // lcg step returning the upper half of the state
    function automatic logic [15:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[31:16];
    endfunction

    function automatic logic [63:0] rand64();
        return {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
    endfunction

    function automatic logic [63:0] sext_word(input logic [63:0] v);
        return {{32{v[31]}}, v[31:0]};
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] got);
        errors++;
        $display("MISMATCH t=%0t %s expected %0h got %0h", $time, name, exp, got);
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // expected result and taken from the RV64 rules
    task automatic model(input alu_op_t o, input logic w, input logic [63:0] x,
                         input logic [63:0] y, output logic [63:0] r, output logic t);
        logic [5:0]  sh;
        logic [31:0] w32;
        logic [63:0] xs;
        logic [63:0] ys;
        logic [63:0] q;
        logic [63:0] rm;
        logic        sgn;
        sh  = w ? {1'b0, y[4:0]} : y[5:0];
        sgn = (o == OP_DIV) || (o == OP_REM);
        xs  = w ? (sgn ? sext_word(x) : {32'b0, x[31:0]}) : x;
        ys  = w ? (sgn ? sext_word(y) : {32'b0, y[31:0]}) : y;
        r   = '0;
        t   = 1'b0;
        case (o)
            OP_ADD:  r = x + y;
            OP_SUB:  r = x - y;
            OP_SLL:  r = x << sh;
            OP_SLT:  r = {63'b0, $signed(x) < $signed(y)};
            OP_SLTU: r = {63'b0, x < y};
            OP_XOR:  r = x ^ y;
            OP_OR:   r = x | y;
            OP_AND:  r = x & y;
            OP_MUL:  r = x * y;
            OP_SRL: begin
                w32 = x[31:0] >> sh;
                r   = w ? {32'b0, w32} : x >> sh;
            end
            OP_SRA: begin
                w32 = $signed(x[31:0]) >>> sh;
                if (w)
                    r = {32'b0, w32};
                else
                    r = $signed(x) >>> sh;
            end
            OP_DIV, OP_DIVU, OP_REM, OP_REMU: begin
                if (ys == '0) begin
                    q  = '1;
                    rm = xs;
                end else if (sgn && xs == 64'h8000_0000_0000_0000 && ys == '1) begin
                    q  = xs;   // signed overflow
                    rm = '0;
                end else if (sgn) begin
                    q  = $signed(xs) / $signed(ys);
                    rm = $signed(xs) % $signed(ys);
                end else begin
                    q  = xs / ys;
                    rm = xs % ys;
                end
                r = (o == OP_REM || o == OP_REMU) ? rm : q;
            end
            OP_BEQ:  t = x == y;
            OP_BNE:  t = x != y;
            OP_BLT:  t = $signed(x) < $signed(y);
            OP_BGE:  t = $signed(x) >= $signed(y);
            OP_BLTU: t = x < y;
            OP_BGEU: t = x >= y;
            default: ;
        endcase
        if (w)
            r = sext_word(r);
    endtask

    // runs one full four-phase transfer starting and ending on a falling edge
    task automatic run_op(input alu_op_t o, input logic w, input logic [63:0] x,
                          input logic [63:0] y);
        logic [63:0] exp_r;
        logic        exp_t;
        int          lat;
        int          hold;
        bit          is_div;
        model(o, w, x, y, exp_r, exp_t);
        is_div = o inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
        op   = o;
        word = w;
        src1 = x;
        src2 = y;
        req  = 1'b1;
        lat  = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!ack && lat < DIV_LAT + 16);
        if (!ack) begin
            report_failure($sformatf("ack never rose for %s", o.name()));
        end else begin
            assert (lat == (is_div ? DIV_LAT : ALU_LAT))
                else report_mismatch("ack latency", 64'(is_div ? DIV_LAT : ALU_LAT), 64'(lat));
            assert (result === exp_r) else report_mismatch("result", exp_r, result);
            assert (taken === exp_t) else report_mismatch("taken", 64'(exp_t), 64'(taken));
            // stall with fresh operands on the bus, nothing new may start
            hold = int'(lcg_next() % 16'd4);
            repeat (hold) begin
                op   = alu_op_t'(5'(lcg_next() % 16'd21));
                src1 = rand64();
                @(negedge clk);
                assert (ack) else report_failure("ack dropped while req was held");
                assert (result === exp_r) else report_mismatch("held result", exp_r, result);
            end
        end
        req = 1'b0;
        @(negedge clk);
        assert (!ack) else report_failure("ack still high a cycle after req fell");
        ops_done++;
    endtask

    task automatic random_op();
        alu_op_t     o;
        logic        w;
        logic [63:0] x;
        logic [63:0] y;
        logic [15:0] pick;
        o    = alu_op_t'(5'(lcg_next() % 16'd21));
        w    = 1'(lcg_next() >> 15);
        x    = rand64();
        y    = rand64();
        pick = lcg_next() % 16'd8;
        case (pick)
            16'd0: y = x;                                // equal operands
            16'd1: y = x ^ 64'h8000_0000_0000_0000;      // sign bit only
            16'd2: y = '0;                               // divide by zero
            16'd3: begin
                x = w ? 64'h0000_0000_8000_0000 : 64'h8000_0000_0000_0000;
                y = '1;
            end
            default: ;
        endcase
        run_op(o, w, x, y);
    endtask

    // reset lands while the divider is iterating
    task automatic reset_mid_divide();
        op   = OP_DIV;
        word = 1'b0;
        src1 = rand64();
        src2 = rand64();
        req  = 1'b1;
        repeat (10) @(negedge clk);
        reset = 1'b1;
        req   = 1'b0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        // the aborted division must never come back with an ack
        repeat (DIV_LAT) begin
            @(negedge clk);
            assert (!ack) else report_failure("ack rose after reset aborted a division");
        end
    endtask

    initial begin
        int total;
        seed  = 32'd16;
        reset = 1'b1;
        req   = 1'b0;
        op    = OP_ADD;
        word  = 1'b0;
        src1  = '0;
        src2  = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        // corner cases first
        run_op(OP_DIV, 1'b0, 64'h0000_0000_0000_1234, 64'h0);
        run_op(OP_DIV, 1'b0, 64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff);
        run_op(OP_REM, 1'b1, 64'h0000_0000_8000_0000, 64'hffff_ffff_ffff_ffff);
        run_op(OP_REMU, 1'b1, 64'h1234_5678_9abc_def0, 64'hffff_ffff_0000_0000);
        run_op(OP_SRA, 1'b1, 64'h0000_0000_8000_0010, 64'hffff_ffff_ffff_ffe4);

        for (int n = 0; n < NUM_OPS - 7; n++)
            random_op();

        reset_mid_divide();
        run_op(OP_DIVU, 1'b0, rand64(), rand64());

        total = errors + uut.u_asserts.fail_cnt;
        $display("operations %0d, check errors %0d, assertion failures %0d",
                 ops_done, errors, uut.u_asserts.fail_cnt);
        if (total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_rv_exec_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_cfg.svh"

module tb_rv_exec_asserts (
    input logic                clk,
    input logic                reset,
    input logic                req,
    input logic                ack,
    input logic [`RV_XLEN-1:0] result,
    input logic                taken
);

    int fail_cnt = 0;   // failed properties so far

    // ack is low once a reset edge has been seen
    ack_low_in_reset: assert property (@(posedge clk) reset |=> !ack)
        else begin
            fail_cnt++;
            $error("ack high after a reset cycle");
        end

    // ack only rises for a request sampled high on the previous edge
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(req))
        else begin
            fail_cnt++;
            $error("ack rose without a request");
        end

    result_stable: assert property (@(posedge clk) disable iff (reset)
        ack |=> !ack || ($stable(result) && $stable(taken)))
        else begin
            fail_cnt++;
            $error("result or taken changed while ack was high");
        end

    // release phase
    ack_follows_req: assert property (@(posedge clk) disable iff (reset)
        (ack && !req) |=> !ack)
        else begin
            fail_cnt++;
            $error("ack did not fall one cycle after req fell");
        end

endmodule

`default_nettype wire

// ==== rv_exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_cfg.svh"

module rv_exec_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    input  rv_exec_pkg::alu_op_t  op,
    input  logic                  word,
    input  logic [`RV_XLEN-1:0]   src1,
    input  logic [`RV_XLEN-1:0]   src2,
    output logic                  ack,
    output logic [`RV_XLEN-1:0]   result,
    output logic                  taken
);

    import rv_exec_pkg::*;

    alu_op_t             alu_op;
    logic                alu_word;
    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic                alu_taken;

    logic                div_start;
    logic                div_signed;
    logic                div_rem;
    logic                div_word;
    logic                div_done;
    logic [`RV_XLEN-1:0] div_result;

    rv_exec_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .op         (op),
        .word       (word),
        .src1       (src1),
        .src2       (src2),
        .ack        (ack),
        .result     (result),
        .taken      (taken),
        .alu_op     (alu_op),
        .alu_word   (alu_word),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_result (alu_result),
        .alu_taken  (alu_taken),
        .div_start  (div_start),
        .div_signed (div_signed),
        .div_rem    (div_rem),
        .div_word   (div_word),
        .div_done   (div_done),
        .div_result (div_result)
    );

    rv_alu u_alu (
        .op     (alu_op),
        .word   (alu_word),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .taken  (alu_taken)
    );

    // divider shares the latched operands with the ALU
    rv_divider u_div (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .is_signed (div_signed),
        .want_rem  (div_rem),
        .word      (div_word),
        .dividend  (alu_a),
        .divisor   (alu_b),
        .done      (div_done),
        .result    (div_result)
    );

endmodule

`default_nettype wire

// ==== rv_exec_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_cfg.svh"

module rv_exec_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    input  rv_exec_pkg::alu_op_t  op,
    input  logic                  word,
    input  logic [`RV_XLEN-1:0]   src1,
    input  logic [`RV_XLEN-1:0]   src2,
    output logic                  ack,
    output logic [`RV_XLEN-1:0]   result,
    output logic                  taken,
    // ALU side
    output rv_exec_pkg::alu_op_t  alu_op,
    output logic                  alu_word,
    output logic [`RV_XLEN-1:0]   alu_a,
    output logic [`RV_XLEN-1:0]   alu_b,
    input  logic [`RV_XLEN-1:0]   alu_result,
    input  logic                  alu_taken,
    // divider side
    output logic                  div_start,
    output logic                  div_signed,
    output logic                  div_rem,
    output logic                  div_word,
    input  logic                  div_done,
    input  logic [`RV_XLEN-1:0]   div_result
);

    import rv_exec_pkg::*;

    exec_state_t state;

    alu_op_t             op_q;
    logic                word_q;
    logic [`RV_XLEN-1:0] a_q;
    logic [`RV_XLEN-1:0] b_q;

    logic                idle;
    logic                accept;
    logic                op_is_div;
    logic                load_result;
    logic [`RV_XLEN-1:0] pick;
    logic [`RV_XLEN-1:0] pick_ext;

    assign idle   = state == S_IDLE;
    assign accept = idle && req;

    // straight from the request while idle so the ALU result can be taken on
    // the accept edge, from the latch afterwards
    assign alu_op   = idle ? op : op_q;
    assign alu_word = idle ? word : word_q;
    assign alu_a    = idle ? src1 : a_q;
    assign alu_b    = idle ? src2 : b_q;

    assign op_is_div = alu_op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};

    // divide decode, valid from the cycle div_start is high
    assign div_signed = (op_q == OP_DIV) || (op_q == OP_REM);
    assign div_rem    = (op_q == OP_REM) || (op_q == OP_REMU);
    assign div_word   = word_q;

    assign load_result = (accept && !op_is_div) || (state == S_DIV && div_done);

    assign pick     = (state == S_DIV) ? div_result : alu_result;
    assign pick_ext = alu_word ? {{(`RV_XLEN-`RV_WLEN){pick[`RV_WLEN-1]}},
                                  pick[`RV_WLEN-1:0]}
                               : pick;

    assign ack = state == S_DONE;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= S_IDLE;
            div_start <= 1'b0;
        end else begin
            div_start <= 1'b0;   // one-cycle pulse
            case (state)
                S_IDLE: begin
                    if (req) begin
                        if (op_is_div) begin
                            div_start <= 1'b1;
                            state     <= S_DIV;
                        end else begin
                            state <= S_DONE;
                        end
                    end
                end
                S_DIV: begin
                    if (div_done)
                        state <= S_DONE;
                end
                S_DONE: begin
                    if (!req)
                        state <= S_IDLE;   // held here while requester stalls
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // request latch and result register
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= op;
            word_q <= word;
            a_q    <= src1;
            b_q    <= src2;
        end
        if (load_result) begin
            result <= pick_ext;
            taken  <= idle ? alu_taken : 1'b0;   // divides never branch
        end
    end

endmodule

`default_nettype wire

// ==== rv_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_cfg.svh"

module rv_divider (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                is_signed,
    input  logic                want_rem,
    input  logic                word,
    input  logic [`RV_XLEN-1:0] dividend,
    input  logic [`RV_XLEN-1:0] divisor,
    output logic                done,
    output logic [`RV_XLEN-1:0] result
);

    typedef enum logic [1:0] {
        D_IDLE,
        D_ITER,
        D_FIX
    } div_state_t;

    div_state_t state;

    logic [$clog2(`RV_DIV_STEPS)-1:0] step_cnt;

    logic [`RV_XLEN-1:0] dvd_ext;
    logic [`RV_XLEN-1:0] dsr_ext;
    logic                dvd_neg;
    logic                dsr_neg;
    logic [`RV_XLEN-1:0] dvd_abs;
    logic [`RV_XLEN-1:0] dsr_abs;

    logic [`RV_XLEN-1:0] quo;     // starts as |dividend|, shifts into quotient
    logic [`RV_XLEN-1:0] rem;     // partial remainder
    logic [`RV_XLEN-1:0] dsr;
    logic                neg_q;
    logic                neg_r;
    logic                rem_sel;
    logic                word_q;

    logic [`RV_XLEN:0]   trial;
    logic [`RV_XLEN-1:0] q_fix;
    logic [`RV_XLEN-1:0] r_fix;
    logic [`RV_XLEN-1:0] pick;

    // word ops divide the low halves, extended per signedness
    always_comb begin
        dvd_ext = dividend;
        dsr_ext = divisor;
        if (word) begin
            dvd_ext = {{(`RV_XLEN-`RV_WLEN){is_signed & dividend[`RV_WLEN-1]}},
                       dividend[`RV_WLEN-1:0]};
            dsr_ext = {{(`RV_XLEN-`RV_WLEN){is_signed & divisor[`RV_WLEN-1]}},
                       divisor[`RV_WLEN-1:0]};
        end
    end

    assign dvd_neg = is_signed & dvd_ext[`RV_XLEN-1];
    assign dsr_neg = is_signed & dsr_ext[`RV_XLEN-1];
    assign dvd_abs = dvd_neg ? -dvd_ext : dvd_ext;
    assign dsr_abs = dsr_neg ? -dsr_ext : dsr_ext;

    // shift in next dividend bit and try the subtract, bit XLEN is the borrow
    assign trial = {rem, quo[`RV_XLEN-1]} - {1'b0, dsr};

    assign q_fix = neg_q ? -quo : quo;
    assign r_fix = neg_r ? -rem : rem;
    assign pick  = rem_sel ? r_fix : q_fix;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= D_IDLE;
            done     <= 1'b0;
            step_cnt <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                D_IDLE: begin
                    if (start) begin
                        step_cnt <= '0;
                        state    <= D_ITER;
                    end
                end
                D_ITER: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == ($clog2(`RV_DIV_STEPS))'(`RV_DIV_STEPS - 1))
                        state <= D_FIX;
                end
                D_FIX: begin
                    done  <= 1'b1;
                    state <= D_IDLE;
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (state == D_IDLE && start) begin
            quo     <= dvd_abs;
            rem     <= '0;
            dsr     <= dsr_abs;
            // x/0 keeps the all-ones quotient, so no negate there
            neg_q   <= (dvd_neg ^ dsr_neg) & (|dsr_ext);
            neg_r   <= dvd_neg;                 // remainder follows dividend
            rem_sel <= want_rem;
            word_q  <= word;
        end else if (state == D_ITER) begin
            if (!trial[`RV_XLEN]) begin
                rem <= trial[`RV_XLEN-1:0];
                quo <= {quo[`RV_XLEN-2:0], 1'b1};
            end else begin
                rem <= {rem[`RV_XLEN-2:0], quo[`RV_XLEN-1]};
                quo <= {quo[`RV_XLEN-2:0], 1'b0};
            end
        end
        // min / -1 falls out of the negate, quotient wraps back to the dividend
        if (state == D_FIX) begin
            result <= word_q ? {{(`RV_XLEN-`RV_WLEN){pick[`RV_WLEN-1]}}, pick[`RV_WLEN-1:0]}
                             : pick;
        end
    end

endmodule

`default_nettype wire

// ==== rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_exec_cfg.svh"

module rv_alu (
    input  rv_exec_pkg::alu_op_t  op,
    input  logic                  word,
    input  logic [`RV_XLEN-1:0]   a,
    input  logic [`RV_XLEN-1:0]   b,
    output logic [`RV_XLEN-1:0]   result,
    output logic                  taken
);

    import rv_exec_pkg::*;

    logic [`RV_SHAMT_D-1:0] shamt;
    logic [`RV_XLEN-1:0]    srl_src;
    logic [`RV_XLEN-1:0]    sra_src;
    logic [`RV_XLEN-1:0]    raw;
    logic                   lt_s;
    logic                   lt_u;
    logic                   eq;

    // word shifts only look at b[4:0]
    assign shamt = word ? {1'b0, b[`RV_SHAMT_W-1:0]} : b[`RV_SHAMT_D-1:0];

    // right shift sources, narrowed to the low half for word ops
    assign srl_src = word ? {{(`RV_XLEN-`RV_WLEN){1'b0}}, a[`RV_WLEN-1:0]} : a;
    assign sra_src = word ? {{(`RV_XLEN-`RV_WLEN){a[`RV_WLEN-1]}}, a[`RV_WLEN-1:0]} : a;

    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;
    assign eq   = a == b;

    always_comb begin
        raw   = '0;
        taken = 1'b0;
        case (op)
            OP_ADD:  raw = a + b;
            OP_SUB:  raw = a - b;
            OP_SLL:  raw = a << shamt;
            OP_SLT:  raw = {{(`RV_XLEN-1){1'b0}}, lt_s};
            OP_SLTU: raw = {{(`RV_XLEN-1){1'b0}}, lt_u};
            OP_XOR:  raw = a ^ b;
            OP_SRL:  raw = srl_src >> shamt;
            OP_SRA:  raw = $signed(sra_src) >>> shamt;   // sign fill
            OP_OR:   raw = a | b;
            OP_AND:  raw = a & b;
            OP_MUL:  raw = a * b;                        // truncates to low half
            OP_BEQ:  taken = eq;
            OP_BNE:  taken = !eq;
            OP_BLT:  taken = lt_s;
            OP_BGE:  taken = !lt_s;
            OP_BLTU: taken = lt_u;
            OP_BGEU: taken = !lt_u;
            // divide group is handled by rv_divider
            default: begin
                raw   = '0;
                taken = 1'b0;
            end
        endcase
    end

    // word results sign-extend from bit 31
    // branch results are zero either way
    assign result = word ? {{(`RV_XLEN-`RV_WLEN){raw[`RV_WLEN-1]}}, raw[`RV_WLEN-1:0]}
                         : raw;

endmodule

`default_nettype wire

// ==== rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

    // execute opcodes
    // the word flag travels beside the opcode, so addw is OP_ADD with word set
    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_MUL,     // low 64 bits of the product only
        // iterative divider group
        OP_DIV,
        OP_DIVU,
        OP_REM,
        OP_REMU,
        // branch compares, outcome on taken
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU
    } alu_op_t;

    // controller FSM
    typedef enum logic [1:0] {
        S_IDLE,     // waiting for req
        S_DIV,      // divider busy
        S_DONE      // ack high, result held until req drops
    } exec_state_t;

endpackage

`default_nettype wire

// ==== rv_exec_cfg.svh ====
`ifndef RV_EXEC_CFG_SVH
`define RV_EXEC_CFG_SVH

// full register width and the word half used by the *w opcodes
`define RV_XLEN 64
`define RV_WLEN 32

// shift amount widths
`define RV_SHAMT_D 6   // double shifts, b[5:0]
`define RV_SHAMT_W 5   // word shifts, b[4:0]

// restoring divider retires one quotient bit per iteration
`define RV_DIV_STEPS `RV_XLEN

`endif
